//--- hdl/csr_pkg.sv
// ====================
// CSR package
// Addresses, operation codes, field positions and types
// shared by the machine-mode CSR file
// ====================

package csr_pkg;

  // ====================
  // Width types
  typedef logic [11:0] csr_addr_t;  // [11:10] RO marker, [9:8] min privilege
  typedef logic [1:0]  priv_t;      // 00 User, 11 Machine
  typedef logic [4:0]  cause_t;     // Trap cause code
  typedef logic [2:0]  csr_op_t;    // funct3 of the CSR instruction

  // CSR operations (funct3)
  localparam csr_op_t CSR_RW  = 3'b001;
  localparam csr_op_t CSR_RS  = 3'b010;
  localparam csr_op_t CSR_RC  = 3'b011;
  localparam csr_op_t CSR_RWI = 3'b101;
  localparam csr_op_t CSR_RSI = 3'b110;
  localparam csr_op_t CSR_RCI = 3'b111;

  localparam priv_t PRIV_M = 2'b11;  // Machine mode

  // ====================
  // Implemented CSR addresses
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MIP       = 12'h344;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;  // Identity block, RO by address
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // mstatus fields kept in hardware
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int MSTATUS_MPP_MSB  = 12;

  // mip bits owned by the interrupt pins
  localparam int MIP_MSIP_BIT = 3;
  localparam int MIP_MTIP_BIT = 7;
  localparam int MIP_MEIP_BIT = 11;

  // ====================
  // Identity values
  // Extensions I(8) M(12) A(0) F(5) D(3)
  localparam logic [25:0] MISA_EXT = 26'h000_1129;
  localparam int unsigned MIMPID_VALUE = 1;

endpackage

//--- hdl/csr_bus_if.sv
// ====================
// CSR bus
// Write command from the access path plus the current
// register values returned by both register banks
// ====================

`timescale 1ns/1ns

interface csr_bus_if import csr_pkg::*; #(
  parameter int XLEN = 32
) ();

  // Write command
  csr_addr_t        addr;
  logic [XLEN-1:0]  wvalue;     // Result of read-modify-write
  logic             wen;        // Single-cycle write strobe
  logic             trap_hold;  // Trap entry or MRET owns this cycle

  // Register values
  logic [XLEN-1:0]  mstatus;
  logic [XLEN-1:0]  mepc;
  logic [XLEN-1:0]  mcause;
  logic [XLEN-1:0]  mtval;
  logic [XLEN-1:0]  mtvec;
  logic [XLEN-1:0]  mscratch;
  logic [XLEN-1:0]  mie;
  logic [XLEN-1:0]  mip;        // Visible value, pins merged

  modport access (
    output addr, wvalue, wen,
    input  mstatus, mepc, mcause, mtval, mtvec, mscratch, mie, mip
  );

  modport trap_bank (
    output mstatus, mepc, mcause, mtval, trap_hold,
    input  addr, wvalue, wen
  );

  modport machine_bank (
    output mtvec, mscratch, mie, mip,
    input  addr, wvalue, wen, trap_hold
  );

endinterface

//--- hdl/csr_access_check.sv
// ====================
// CSR access check
// Flags unknown CSRs, privilege violations and writes to
// read-only CSRs; produces the write permission
// ====================

`timescale 1ns/1ns

module csr_access_check import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  csr_addr_t csr_addr,
  input  logic      csr_access,    // CSR instruction this cycle
  input  logic      csr_we,        // Instruction intends a write
  input  priv_t     current_priv,
  output logic      illegal_csr,
  output logic      write_ok
);

  logic csr_exists;
  logic priv_ok;
  logic read_only;

  // Implemented set
  always_comb begin
    case (csr_addr)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: csr_exists = 1'b1;
      default:                                              csr_exists = 1'b0;
    endcase
  end

  // Address bits 9:8 hold the lowest privilege allowed
  assign priv_ok = (current_priv >= csr_addr[9:8]);

  // Top bits 11 mark read-only and misa is held fixed
  assign read_only = (csr_addr[11:10] == 2'b11) || (csr_addr == CSR_MISA);

  assign illegal_csr = csr_access && (!csr_exists || !priv_ok || (csr_we && read_only));

  // Write goes ahead on privilege or existence faults as the core drops the instruction
  assign write_ok = csr_we && !read_only;

endmodule

//--- hdl/csr_rw_path.sv
// ====================
// CSR read/write path
// Read mux over bank values and identity constants,
// RMW value for the six CSR instructions
// ====================

`timescale 1ns/1ns

module csr_rw_path import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  csr_addr_t        csr_addr,
  input  logic [XLEN-1:0]  csr_wdata,   // rs1 value or zero-extended uimm
  input  csr_op_t          csr_op,
  input  logic             write_ok,
  output logic [XLEN-1:0]  csr_rdata,
  csr_bus_if.access        bus
);

  // MXL field, 1 for RV32 and 2 for RV64
  localparam logic [1:0] MXL = (XLEN == 64) ? 2'b10 : 2'b01;

  logic [XLEN-1:0] misa_value;

  // ====================
  // Identity registers
  assign misa_value = {MXL, {(XLEN-28){1'b0}}, MISA_EXT};

  // ====================
  // Read mux
  always_comb begin
    case (csr_addr)
      CSR_MSTATUS:   csr_rdata = bus.mstatus;
      CSR_MISA:      csr_rdata = misa_value;
      CSR_MIE:       csr_rdata = bus.mie;
      CSR_MTVEC:     csr_rdata = bus.mtvec;
      CSR_MSCRATCH:  csr_rdata = bus.mscratch;
      CSR_MEPC:      csr_rdata = bus.mepc;
      CSR_MCAUSE:    csr_rdata = bus.mcause;
      CSR_MTVAL:     csr_rdata = bus.mtval;
      CSR_MIP:       csr_rdata = bus.mip;       // Includes pin state
      CSR_MVENDORID: csr_rdata = '0;            // Non-commercial
      CSR_MARCHID:   csr_rdata = '0;
      CSR_MIMPID:    csr_rdata = XLEN'(MIMPID_VALUE);
      CSR_MHARTID:   csr_rdata = '0;            // Single hart
      default:       csr_rdata = '0;            // Unknown reads as zero
    endcase
  end

  // ====================
  // Read-modify-write value
  always_comb begin
    case (csr_op)
      CSR_RW, CSR_RWI: bus.wvalue = csr_wdata;
      CSR_RS, CSR_RSI: bus.wvalue = csr_rdata | csr_wdata;   // Set bits
      CSR_RC, CSR_RCI: bus.wvalue = csr_rdata & ~csr_wdata;  // Clear bits
      default:         bus.wvalue = csr_rdata;               // No change
    endcase
  end

  // Write command to banks
  assign bus.addr = csr_addr;
  assign bus.wen  = write_ok;

endmodule

//--- hdl/csr_trap_regs.sv
// ====================
// Trap register bank
// mstatus, mepc, mcause, mtval with trap entry and MRET
// ====================

`timescale 1ns/1ns

module csr_trap_regs import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             trap_entry,         // One-cycle pulse
  input  logic [XLEN-1:0]  trap_pc,
  input  cause_t           trap_cause,
  input  logic             trap_is_interrupt,
  input  logic [XLEN-1:0]  trap_val,
  input  logic             mret,               // One-cycle pulse
  input  priv_t            current_priv,
  output logic [XLEN-1:0]  mepc_out,
  output logic             mstatus_mie,
  output logic             mstatus_mpie,
  output priv_t            mpp_out,
  csr_bus_if.trap_bank     bus
);

  // mstatus fields, other bits read as zero
  logic             mie_r;
  logic             mpie_r;
  priv_t            mpp_r;
  logic [XLEN-1:0]  mepc_r;
  logic [XLEN-1:0]  mcause_r;
  logic [XLEN-1:0]  mtval_r;

  // ====================
  // Update, priority trap > MRET > CSR write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_r    <= 1'b0;
      mpie_r   <= 1'b0;
      mpp_r    <= PRIV_M;   // Come out of reset as if trapped from M
      mepc_r   <= '0;
      mcause_r <= '0;
      mtval_r  <= '0;
    end else if (trap_entry) begin
      mepc_r   <= trap_pc;
      mcause_r <= {trap_is_interrupt, {(XLEN-6){1'b0}}, trap_cause};
      mtval_r  <= trap_val;
      mpie_r   <= mie_r;         // Stack interrupt enable
      mie_r    <= 1'b0;
      mpp_r    <= current_priv;
    end else if (mret) begin
      mie_r    <= mpie_r;        // Pop interrupt enable
      mpie_r   <= 1'b1;
      mpp_r    <= '0;            // Least privileged mode, U
    end else if (bus.wen) begin
      case (bus.addr)
        CSR_MSTATUS: begin
          mie_r  <= bus.wvalue[MSTATUS_MIE_BIT];
          mpie_r <= bus.wvalue[MSTATUS_MPIE_BIT];
          mpp_r  <= bus.wvalue[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB];
        end
        CSR_MEPC:   mepc_r   <= {bus.wvalue[XLEN-1:1], 1'b0};  // IALIGN 16
        CSR_MCAUSE: mcause_r <= bus.wvalue;
        CSR_MTVAL:  mtval_r  <= bus.wvalue;
        default: ;                                             // Other bank
      endcase
    end
  end

  // mstatus image
  always_comb begin
    bus.mstatus = '0;
    bus.mstatus[MSTATUS_MIE_BIT]  = mie_r;
    bus.mstatus[MSTATUS_MPIE_BIT] = mpie_r;
    bus.mstatus[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB] = mpp_r;
  end

  assign bus.mepc      = mepc_r;
  assign bus.mcause    = mcause_r;
  assign bus.mtval     = mtval_r;
  assign bus.trap_hold = trap_entry || mret;  // Blocks writes in other bank

  assign mepc_out     = mepc_r;
  assign mstatus_mie  = mie_r;
  assign mstatus_mpie = mpie_r;
  assign mpp_out      = mpp_r;

endmodule

//--- hdl/csr_machine_regs.sv
// ====================
// Machine register bank
// mtvec, mscratch, mie and mip with interrupt pins merged
// ====================

`timescale 1ns/1ns

module csr_machine_regs import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             mtip_in,      // Timer, from CLINT
  input  logic             msip_in,      // Software, from CLINT
  input  logic             meip_in,      // External, from PLIC
  output logic [XLEN-1:0]  trap_vector,
  output logic [XLEN-1:0]  mip_out,
  output logic [XLEN-1:0]  mie_out,
  csr_bus_if.machine_bank  bus
);

  // Pin-owned mip positions
  localparam logic [XLEN-1:0] MIP_HW_MASK = (XLEN'(1) << MIP_MEIP_BIT) |
                                            (XLEN'(1) << MIP_MTIP_BIT) |
                                            (XLEN'(1) << MIP_MSIP_BIT);

  logic [XLEN-1:0] mtvec_r;
  logic [XLEN-1:0] mscratch_r;
  logic [XLEN-1:0] mie_r;
  logic [XLEN-1:0] mip_sw_r;     // Software bits only
  logic [XLEN-1:0] mip_value;
  logic            wr;

  // Trap entry and MRET take the cycle
  assign wr = bus.wen && !bus.trap_hold;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtvec_r    <= '0;
      mscratch_r <= '0;
      mie_r      <= '0;
      mip_sw_r   <= '0;
    end else if (wr) begin
      case (bus.addr)
        CSR_MTVEC:    mtvec_r    <= {bus.wvalue[XLEN-1:2], 2'b00};  // Direct mode, 4B
        CSR_MSCRATCH: mscratch_r <= bus.wvalue;
        CSR_MIE:      mie_r      <= bus.wvalue;
        CSR_MIP:      mip_sw_r   <= bus.wvalue & ~MIP_HW_MASK;
        default: ;
      endcase
    end
  end

  // ====================
  // Visible mip
  always_comb begin
    mip_value = mip_sw_r;
    mip_value[MIP_MEIP_BIT] = meip_in;
    mip_value[MIP_MTIP_BIT] = mtip_in;
    mip_value[MIP_MSIP_BIT] = msip_in;
  end

  assign bus.mtvec    = mtvec_r;
  assign bus.mscratch = mscratch_r;
  assign bus.mie      = mie_r;
  assign bus.mip      = mip_value;

  assign trap_vector = mtvec_r;
  assign mip_out     = mip_value;
  assign mie_out     = mie_r;

endmodule

//--- hdl/csr_top.sv
// ====================
// Machine-mode CSR file
// Access check, RMW path and two register banks
// ====================

`timescale 1ns/1ns

module csr_top import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic             clk,
  input  logic             reset_n,
  // CSR instruction
  input  csr_addr_t        csr_addr,
  input  logic [XLEN-1:0]  csr_wdata,
  input  csr_op_t          csr_op,
  input  logic             csr_we,
  input  logic             csr_access,
  output logic [XLEN-1:0]  csr_rdata,
  output logic             illegal_csr,
  // Trap and return
  input  logic             trap_entry,
  input  logic [XLEN-1:0]  trap_pc,
  input  cause_t           trap_cause,
  input  logic             trap_is_interrupt,
  input  logic [XLEN-1:0]  trap_val,
  input  logic             mret,
  input  priv_t            current_priv,
  output logic [XLEN-1:0]  trap_vector,
  output logic [XLEN-1:0]  mepc_out,
  output logic             mstatus_mie,
  output logic             mstatus_mpie,
  output priv_t            mpp_out,
  // Interrupts
  input  logic             mtip_in,
  input  logic             msip_in,
  input  logic             meip_in,
  output logic [XLEN-1:0]  mip_out,
  output logic [XLEN-1:0]  mie_out
);

  logic write_ok;

  csr_bus_if #(.XLEN(XLEN)) bus ();

  csr_access_check #(.XLEN(XLEN)) u_access_check (
    .csr_addr     (csr_addr),
    .csr_access   (csr_access),
    .csr_we       (csr_we),
    .current_priv (current_priv),
    .illegal_csr  (illegal_csr),
    .write_ok     (write_ok)
  );

  csr_rw_path #(.XLEN(XLEN)) u_rw_path (
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_op    (csr_op),
    .write_ok  (write_ok),
    .csr_rdata (csr_rdata),
    .bus       (bus.access)
  );

  csr_trap_regs #(.XLEN(XLEN)) u_trap_regs (
    .clk               (clk),
    .reset_n           (reset_n),
    .trap_entry        (trap_entry),
    .trap_pc           (trap_pc),
    .trap_cause        (trap_cause),
    .trap_is_interrupt (trap_is_interrupt),
    .trap_val          (trap_val),
    .mret              (mret),
    .current_priv      (current_priv),
    .mepc_out          (mepc_out),
    .mstatus_mie       (mstatus_mie),
    .mstatus_mpie      (mstatus_mpie),
    .mpp_out           (mpp_out),
    .bus               (bus.trap_bank)
  );

  csr_machine_regs #(.XLEN(XLEN)) u_machine_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .mtip_in     (mtip_in),
    .msip_in     (msip_in),
    .meip_in     (meip_in),
    .trap_vector (trap_vector),
    .mip_out     (mip_out),
    .mie_out     (mie_out),
    .bus         (bus.machine_bank)
  );

endmodule

//--- verif/tb_clock_gen.sv
// ====================
// Testbench clock source
// Free-running clock, 100 ns period
// ====================

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;                        // Start low, first rise at half period
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- verif/tb_csr_top.sv
// ====================
// Testbench for the machine-mode CSR file
// LFSR stimulus checked against a register model
// ====================

`timescale 1ns/1ns

module tb_csr_top import csr_pkg::*;;

  logic clk, reset_n;
  csr_addr_t csr_addr;
  logic [31:0] csr_wdata, trap_pc, trap_val;
  csr_op_t csr_op;
  logic csr_we, csr_access, trap_entry, trap_is_interrupt, mret;
  cause_t trap_cause;
  priv_t current_priv, mpp_out;
  logic mtip_in, msip_in, meip_in;
  logic [31:0] csr_rdata, trap_vector, mepc_out, mip_out, mie_out;
  logic illegal_csr, mstatus_mie, mstatus_mpie;

  // ====================
  // Register model
  logic m_mie, m_mpie;
  priv_t m_mpp;
  logic [31:0] m_mepc, m_mcause, m_mtval, m_mtvec, m_mscratch, m_mie_reg, m_mip_sw;

  logic [15:0] lfsr = 16'd29;          // Seed
  int checks = 0;
  int errors = 0;
  int errors_mark = 0;
  logic [2:0] pick3;
  logic [3:0] pick4;

  csr_addr_t writable [8] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                              CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP};
  // Implemented set followed by mcounteren, sstatus and cycle which are absent
  csr_addr_t pool [16] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                           CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MVENDORID,
                           CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
                           12'h306, 12'h100, 12'hC00};
  csr_op_t ops [6] = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};

  tb_clock_gen #(.PERIOD_NS(100)) clock_gen (.clk(clk));

  csr_top #(.XLEN(32)) UUT (.*);

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic read_only(input csr_addr_t addr);
    return (addr[11:10] == 2'b11) || (addr == CSR_MISA);
  endfunction

  function automatic logic model_read_ok(input csr_addr_t addr);
    foreach (pool[i]) begin
      if (i < 13 && pool[i] == addr) return 1'b1;   // First 13 exist
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] model_read(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:  return {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
      CSR_MISA:     return 32'h4000_1129;        // MXL 1 with I M A F D
      CSR_MIE:      return m_mie_reg;
      CSR_MTVEC:    return m_mtvec;
      CSR_MSCRATCH: return m_mscratch;
      CSR_MEPC:     return m_mepc;
      CSR_MCAUSE:   return m_mcause;
      CSR_MTVAL:    return m_mtval;
      CSR_MIP:      return (m_mip_sw & ~32'h888) |
                           {20'b0, meip_in, 3'b0, mtip_in, 3'b0, msip_in, 3'b0};
      CSR_MIMPID:   return 32'd1;
      default:      return 32'd0;                // Zero identity registers and unknown
    endcase
  endfunction

  // Low funct3 bits select write (01), set (10) or clear (11)
  function automatic logic [31:0] rmw_value(input csr_op_t op, input logic [31:0] old_value,
                                            input logic [31:0] operand);
    case (op[1:0])
      2'b01:   return operand;
      2'b10:   return old_value | operand;
      2'b11:   return old_value & ~operand;
      default: return old_value;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  // Commit the driven inputs into the model on the rising edge
  task automatic clock_model();
    logic [31:0] new_value;
    @(posedge clk);
    new_value = rmw_value(csr_op, model_read(csr_addr), csr_wdata);
    if (trap_entry) begin
      m_mepc   = trap_pc;
      m_mcause = {trap_is_interrupt, 26'b0, trap_cause};
      m_mtval  = trap_val;
      m_mpie   = m_mie;
      m_mie    = 1'b0;
      m_mpp    = current_priv;
    end else if (mret) begin
      m_mie  = m_mpie;
      m_mpie = 1'b1;
      m_mpp  = 2'b00;
    end else if (csr_we && !read_only(csr_addr)) begin
      case (csr_addr)
        CSR_MSTATUS: {m_mpp, m_mpie, m_mie} = {new_value[12:11], new_value[7], new_value[3]};
        CSR_MIE:      m_mie_reg  = new_value;
        CSR_MTVEC:    m_mtvec    = {new_value[31:2], 2'b00};
        CSR_MSCRATCH: m_mscratch = new_value;
        CSR_MEPC:     m_mepc     = {new_value[31:1], 1'b0};
        CSR_MCAUSE:   m_mcause   = new_value;
        CSR_MTVAL:    m_mtval    = new_value;
        CSR_MIP:      m_mip_sw   = new_value & ~32'h888;   // Pin bits not stored
        default: ;
      endcase
    end
    @(negedge clk);
  endtask

  task automatic drive_idle();
    csr_we = 1'b0;
    csr_access = 1'b0;
    csr_op = 3'b000;
    trap_entry = 1'b0;
    mret = 1'b0;
  endtask

  // One-cycle read checked mid-cycle
  task automatic read_check(input csr_addr_t addr);
    drive_idle();
    csr_addr = addr;
    csr_access = 1'b1;
    #10;
    compare_value($sformatf("csr_rdata[%h]", addr), model_read(addr), csr_rdata);
    clock_model();
  endtask

  task automatic report_test(input string name);
    $display("test %s done: errors %0d", name, errors - errors_mark);
    errors_mark = errors;
  endtask

  task automatic wait_reset_state();
    int cycles;
    cycles = 0;
    while (!(mpp_out == 2'b11 && trap_vector == 32'd0)) begin
      @(negedge clk);
      cycles++;
      if (cycles > 16) begin
        $display("Timeout: reset state never appeared after reset release");
        $display("TEST FAILED");
        $finish;
      end
    end
  endtask

  // ====================
  // Test sequence
  initial begin
    reset_n = 1'b0;
    drive_idle();
    csr_addr = '0;
    csr_wdata = '0;
    trap_pc = '0;
    trap_val = '0;
    trap_cause = '0;
    trap_is_interrupt = 1'b0;
    current_priv = 2'b11;
    {mtip_in, msip_in, meip_in} = 3'b000;
    {m_mie, m_mpie, m_mpp} = {1'b0, 1'b0, 2'b11};
    {m_mepc, m_mcause, m_mtval, m_mtvec} = '0;
    {m_mscratch, m_mie_reg, m_mip_sw} = '0;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    wait_reset_state();

    // Test 1 checks reset values against literals
    csr_access = 1'b1;
    csr_addr = CSR_MSTATUS;
    #5 compare_value("mstatus", 32'h1800, csr_rdata);
    csr_addr = CSR_MISA;
    #5 compare_value("misa", 32'h4000_1129, csr_rdata);
    csr_addr = CSR_MIMPID;
    #5 compare_value("mimpid", 32'd1, csr_rdata);
    foreach (pool[i]) begin
      if (i >= 9 && i != 11 && i < 13) begin
        csr_addr = pool[i];
        #5 compare_value($sformatf("ident[%h]", pool[i]), 32'd0, csr_rdata);
      end
    end
    compare_value("trap_vector", 32'd0, trap_vector);
    compare_value("mepc_out", 32'd0, mepc_out);
    clock_model();
    report_test("1 reset values");

    // Test 2 runs random CSR instructions in M mode
    repeat (200) begin
      pick3 = 3'(random_bits(3));
      csr_addr = writable[pick3];
      pick3 = 3'(random_bits(3));
      if (pick3 > 3'd5) pick3 = pick3 - 3'd6;
      csr_op = ops[pick3];
      csr_wdata = csr_op[2] ? {27'b0, 5'(random_bits(5))} : random_bits(32);  // uimm
      csr_we = 1'b1;
      csr_access = 1'b1;
      #10;
      compare_value("illegal_csr", 32'd0, 32'(illegal_csr));
      compare_value("csr_rdata old", model_read(csr_addr), csr_rdata);
      clock_model();
      read_check(csr_addr);
      compare_value("mie_out", m_mie_reg, mie_out);
      compare_value("trap_vector", m_mtvec, trap_vector);
    end
    report_test("2 random csr ops");

    // Test 3 checks the existence, privilege and read-only rule
    repeat (150) begin
      pick4 = 4'(random_bits(4));
      csr_addr = pool[pick4];
      current_priv = priv_t'(random_bits(2));
      csr_we = 1'(random_bits(1));
      csr_access = 1'(random_bits(1));
      csr_op = csr_op_t'(random_bits(3));
      csr_wdata = random_bits(32);
      #10;
      compare_value($sformatf("illegal_csr[%h]", csr_addr),
                    32'(csr_access && (!model_read_ok(csr_addr) ||
                        current_priv < csr_addr[9:8] || (csr_we && read_only(csr_addr)))),
                    32'(illegal_csr));
      clock_model();
    end
    current_priv = 2'b11;
    report_test("3 illegal access");

    // Test 4 shows pins in mip the same cycle whatever software writes
    repeat (20) begin
      {meip_in, mtip_in, msip_in} = 3'(random_bits(3));
      read_check(CSR_MIP);
      compare_value("mip_out", model_read(CSR_MIP), mip_out);
      csr_addr = CSR_MIP;
      csr_op = CSR_RS;
      csr_wdata = 32'h888;
      csr_we = 1'b1;
      clock_model();
      {meip_in, mtip_in, msip_in} = 3'(random_bits(3));
      read_check(CSR_MIP);
    end
    report_test("4 interrupt pins");

    // Test 5 collides a trap with an mscratch write and follows with MRET
    repeat (8) begin
      drive_idle();
      csr_addr = CSR_MSTATUS;
      csr_op = 1'(random_bits(1)) ? CSR_RS : CSR_RC;  // MIE random before trap
      csr_wdata = 32'h8;
      csr_we = 1'b1;
      clock_model();
      csr_addr = CSR_MSCRATCH;
      csr_op = CSR_RW;
      csr_wdata = random_bits(32);
      trap_entry = 1'b1;
      trap_pc = random_bits(32);
      trap_cause = cause_t'(random_bits(5));
      trap_is_interrupt = 1'(random_bits(1));
      trap_val = random_bits(32);
      current_priv = priv_t'(random_bits(2));
      clock_model();
      drive_idle();
      compare_value("mepc_out", m_mepc, mepc_out);
      compare_value("mstatus_mie", 32'(m_mie), 32'(mstatus_mie));
      compare_value("mstatus_mpie", 32'(m_mpie), 32'(mstatus_mpie));
      compare_value("mpp_out", 32'(m_mpp), 32'(mpp_out));
      read_check(CSR_MCAUSE);
      read_check(CSR_MTVAL);
      read_check(CSR_MSCRATCH);                 // Write lost to trap
      mret = 1'b1;
      clock_model();
      drive_idle();
      compare_value("mstatus_mie", 32'(m_mie), 32'(mstatus_mie));
      compare_value("mstatus_mpie", 32'd1, 32'(mstatus_mpie));
      compare_value("mpp_out", 32'd0, 32'(mpp_out));
    end
    report_test("5 trap and mret");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access_check.sv
hdl/csr_rw_path.sv
hdl/csr_trap_regs.sv
hdl/csr_machine_regs.sv
hdl/csr_top.sv
verif/tb_clock_gen.sv
verif/tb_csr_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_csr_top -f files.f \
  --Mdir obj_dir -o sim_csr_top
./obj_dir/sim_csr_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
